//--- design/ae_defines.svh
`ifndef AE_DEFINES_SVH
`define AE_DEFINES_SVH

// datapath widths
`define AE_PIX_W            8
`define AE_BINS             256
`define AE_CNT_W            24
`define AE_WSUM_W           32
`define AE_IDX_W            7

// exposure index and brightness target
`define AE_IDX_MAX          95
`define AE_IDX_DEFAULT      61
`define AE_TARGET_DEFAULT   110
`define AE_TARGET_STEP      20
`define AE_TARGET_HI_LIMIT  230
`define AE_TARGET_LO_LIMIT  40
`define AE_EV_GAIN          32
`define AE_EV_STEP_MAX      8

// bracket offsets around the main index
`define AE_BRACKET_UP       15
`define AE_BRACKET_DN1      10
`define AE_BRACKET_DN2      50

// exposure table rule and output credits
`define AE_IT_UNIT          16
`define AE_IT_MAX           1024
`define AE_AG_UNITY         256
`define AE_AG_STEP          32
`define AE_CREDITS          2

`endif

//--- design/ae_pkg.sv
`include "ae_defines.svh"

package ae_pkg;

	// ==================================================
	// vector types
	// ==================================================
	typedef logic [`AE_PIX_W-1:0]  pix_t;      // luminance, also bin number
	typedef logic [`AE_CNT_W-1:0]  bin_cnt_t;
	typedef logic [`AE_WSUM_W-1:0] wsum_t;
	typedef logic [`AE_IDX_W-1:0]  exp_idx_t;
	typedef logic signed [5:0]     ev_step_t;  // holds +-AE_EV_STEP_MAX
	typedef logic [7:0]            target_t;
	typedef logic [15:0]           cfg_word_t;
	typedef logic [1:0]            bracket_t;

	// ==================================================
	// state machines
	// ==================================================
	typedef enum logic {
		HIST_COLLECT,
		HIST_READOUT
	} hist_state_t;

	typedef enum logic [1:0] {
		EV_IDLE,
		EV_DIV_MEAN,
		EV_DIV_STEP,
		EV_UPDATE
	} ev_state_t;

	typedef enum logic {
		SND_IDLE,
		SND_SEND
	} send_state_t;

endpackage

//--- design/ae_histogram.sv
`timescale 1ns/1ps
`include "ae_defines.svh"

module ae_histogram (
	input  logic             pix_clk,
	input  logic             reset,
	input  logic             vs_in,
	input  logic             de_in,
	input  ae_pkg::pix_t     data_in,
	output logic             bin_valid,
	output ae_pkg::pix_t     bin_index,
	output ae_pkg::bin_cnt_t bin_count,
	output logic             bins_done
);
	import ae_pkg::*;

	hist_state_t hist_state;
	pix_t        rd_cnt;   // next bin to read out
	logic        vs_q;
	logic        vs_rise;

	// load into the update pipeline
	logic        ld_clr;
	logic        ld_vld;
	pix_t        ld_addr;

	// pipeline stages: s1 reads, s2 adds, s3 writes, w4 just written
	logic        s1_vld;
	logic        s1_clr;
	pix_t        s1_addr;
	logic        s2_vld;
	logic        s2_clr;
	pix_t        s2_addr;
	logic        s3_vld;
	pix_t        s3_addr;
	bin_cnt_t    s3_data;
	logic        w4_vld;
	pix_t        w4_addr;
	bin_cnt_t    w4_data;

	bin_cnt_t    mem [0:`AE_BINS-1];
	bin_cnt_t    rd_q;
	bin_cnt_t    fwd;

	assign vs_rise = vs_in & ~vs_q;

	// readout shares the pipeline, its write-back is a zero
	assign ld_clr  = (hist_state == HIST_READOUT) | vs_rise;
	assign ld_vld  = ld_clr | de_in;
	assign ld_addr = ld_clr ? rd_cnt : data_in;

	always_ff @(posedge pix_clk or posedge reset)
	begin
		if (reset)
		begin
			hist_state <= HIST_COLLECT;
			rd_cnt     <= '0;
			vs_q       <= 1'b1;   // no readout if vblank is high at start
			s1_vld     <= 1'b0;
			s1_clr     <= 1'b0;
			s2_vld     <= 1'b0;
			s2_clr     <= 1'b0;
			s3_vld     <= 1'b0;
			w4_vld     <= 1'b0;
		end
		else
		begin
			vs_q <= vs_in;
			if (ld_clr)
				rd_cnt <= rd_cnt + 1'b1;
			if (hist_state == HIST_COLLECT && vs_rise)
				hist_state <= HIST_READOUT;
			else if (hist_state == HIST_READOUT && rd_cnt == pix_t'(`AE_BINS - 1))
				hist_state <= HIST_COLLECT;
			s1_vld <= ld_vld;
			s1_clr <= ld_clr;
			s2_vld <= s1_vld;
			s2_clr <= s1_clr;
			s3_vld <= s2_vld;
			w4_vld <= s3_vld;
		end
	end

	always_ff @(posedge pix_clk)
	begin
		s1_addr <= ld_addr;
		s2_addr <= s1_addr;
		s3_addr <= s2_addr;
		s3_data <= s2_clr ? '0 : fwd + 1'b1;
		w4_addr <= s3_addr;
		w4_data <= s3_data;
	end

	// read-first RAM, the write on the read edge is not seen
	always_ff @(posedge pix_clk)
	begin
		if (s3_vld)
			mem[s3_addr] <= s3_data;
		rd_q <= mem[s1_addr];
	end

	// newest value wins
	always_comb
	begin
		if (s3_vld && s3_addr == s2_addr)
			fwd = s3_data;
		else if (w4_vld && w4_addr == s2_addr)
			fwd = w4_data;
		else
			fwd = rd_q;
	end

	assign bin_valid = s2_vld & s2_clr;
	assign bin_index = s2_addr;
	assign bin_count = fwd;
	assign bins_done = bin_valid & (s2_addr == pix_t'(`AE_BINS - 1));

	a_no_pixels_in_readout: assert property (@(posedge pix_clk) disable iff (reset)
		(hist_state == HIST_READOUT) |-> !de_in);

endmodule

//--- design/ae_frame_stats.sv
`timescale 1ns/1ps

module ae_frame_stats (
	input  logic             pix_clk,
	input  logic             reset,
	input  logic             bin_valid,
	input  ae_pkg::pix_t     bin_index,
	input  ae_pkg::bin_cnt_t bin_count,
	input  logic             bins_done,
	output logic             stats_valid,
	output ae_pkg::bin_cnt_t pix_count,
	output ae_pkg::wsum_t    weighted_sum
);
	import ae_pkg::*;

	bin_cnt_t cnt_acc;
	wsum_t    wsum_acc;
	wsum_t    prod;

	assign prod = wsum_t'(bin_index) * wsum_t'(bin_count);   // intensity x count

	always_ff @(posedge pix_clk or posedge reset)
	begin
		if (reset)
		begin
			cnt_acc     <= '0;
			wsum_acc    <= '0;
			stats_valid <= 1'b0;
		end
		else
		begin
			stats_valid <= bins_done;
			if (bins_done)
			begin
				cnt_acc  <= '0;   // ready for the next frame
				wsum_acc <= '0;
			end
			else if (bin_valid)
			begin
				cnt_acc  <= cnt_acc + bin_count;
				wsum_acc <= wsum_acc + prod;
			end
		end
	end

	// totals include the last bin, held until the next frame
	always_ff @(posedge pix_clk)
	begin
		if (bins_done)
		begin
			pix_count    <= cnt_acc + bin_count;
			weighted_sum <= wsum_acc + prod;
		end
	end

endmodule

//--- design/ae_divider.sv
`timescale 1ns/1ps
`include "ae_defines.svh"

module ae_divider (
	input  logic          pix_clk,
	input  logic          reset,
	input  logic          div_start,
	input  ae_pkg::wsum_t dividend,
	input  ae_pkg::wsum_t divisor,
	output logic          div_done,
	output ae_pkg::wsum_t quotient
);
	import ae_pkg::*;

	localparam int CNT_W = $clog2(`AE_WSUM_W + 1);

	logic               busy_q;
	logic [CNT_W-1:0]   bit_cnt;
	wsum_t              rem_q;
	wsum_t              quo_q;   // dividend shifts out, quotient shifts in
	wsum_t              dvs_q;
	logic [`AE_WSUM_W:0] rem_sh;
	logic [`AE_WSUM_W:0] trial;
	logic               fits;

	assign rem_sh = {rem_q, quo_q[`AE_WSUM_W-1]};
	assign trial  = rem_sh - {1'b0, dvs_q};
	assign fits   = rem_sh >= {1'b0, dvs_q};

	always_ff @(posedge pix_clk or posedge reset)
	begin
		if (reset)
		begin
			busy_q   <= 1'b0;
			bit_cnt  <= '0;
			div_done <= 1'b0;
		end
		else
		begin
			div_done <= 1'b0;
			if (div_start)
			begin
				busy_q  <= 1'b1;
				bit_cnt <= CNT_W'(`AE_WSUM_W);
			end
			else if (busy_q)
			begin
				bit_cnt <= bit_cnt - 1'b1;
				if (bit_cnt == CNT_W'(1))
				begin
					busy_q   <= 1'b0;
					div_done <= 1'b1;
				end
			end
		end
	end

	// ==================================================
	// restoring step, one quotient bit per cycle
	// ==================================================
	always_ff @(posedge pix_clk)
	begin
		if (div_start)
		begin
			rem_q <= '0;
			quo_q <= dividend;
			dvs_q <= divisor;
		end
		else if (busy_q)
		begin
			rem_q <= fits ? trial[`AE_WSUM_W-1:0] : rem_sh[`AE_WSUM_W-1:0];
			quo_q <= {quo_q[`AE_WSUM_W-2:0], fits};
			if (bit_cnt == CNT_W'(1) && dvs_q == '0)
				quo_q <= '0;   // divide by zero reads as zero
		end
	end

	assign quotient = quo_q;

	a_start_when_idle: assert property (@(posedge pix_clk) disable iff (reset)
		div_start |-> !busy_q);

endmodule

//--- design/ae_ev_control.sv
`timescale 1ns/1ps
`include "ae_defines.svh"

module ae_ev_control (
	input  logic               pix_clk,
	input  logic               reset,
	input  logic               ref_bri_up,
	input  logic               ref_bri_down,
	input  logic               stats_valid,
	input  ae_pkg::bin_cnt_t   pix_count,
	input  ae_pkg::wsum_t      weighted_sum,
	output logic               brackets_valid,
	output ae_pkg::exp_idx_t   bracket_idx0,
	output ae_pkg::exp_idx_t   bracket_idx1,
	output ae_pkg::exp_idx_t   bracket_idx2,
	output ae_pkg::exp_idx_t   bracket_idx3
);
	import ae_pkg::*;

	logic [2:0] up_d;
	logic [2:0] dn_d;
	logic       up_rise;
	logic       dn_rise;
	target_t    target_q;
	target_t    target_snap;   // target seen on stats_valid
	ev_state_t  ev_state;
	logic       boot_q;

	logic       div_start;
	wsum_t      dividend;
	wsum_t      divisor;
	logic       div_done;
	wsum_t      quotient;

	logic       mean_gt;
	wsum_t      mean_gap;
	logic       step_neg;
	ev_step_t   step_mag;
	ev_step_t   step_q;
	exp_idx_t   idx_q;
	logic signed [`AE_IDX_W+1:0] idx_sum;
	exp_idx_t   idx_next;

	// ==================================================
	// brightness target
	// ==================================================
	assign up_rise = up_d[1] & ~up_d[2];
	assign dn_rise = dn_d[1] & ~dn_d[2];

	always_ff @(posedge pix_clk or posedge reset)
	begin
		if (reset)
		begin
			up_d     <= '0;
			dn_d     <= '0;
			target_q <= target_t'(`AE_TARGET_DEFAULT);
		end
		else
		begin
			up_d <= {up_d[1:0], ref_bri_up};   // two-flop sync plus edge flop
			dn_d <= {dn_d[1:0], ref_bri_down};
			if (up_rise && target_q <= target_t'(`AE_TARGET_HI_LIMIT))
				target_q <= target_q + target_t'(`AE_TARGET_STEP);
			else if (dn_rise && target_q >= target_t'(`AE_TARGET_LO_LIMIT))
				target_q <= target_q - target_t'(`AE_TARGET_STEP);
		end
	end

	// ==================================================
	// mean and step divisions
	// ==================================================
	assign mean_gt  = quotient > wsum_t'(target_snap);
	assign mean_gap = mean_gt ? quotient - wsum_t'(target_snap)
	                          : wsum_t'(target_snap) - quotient;
	assign step_mag = (quotient > wsum_t'(`AE_EV_STEP_MAX)) ? ev_step_t'(`AE_EV_STEP_MAX)
	                                                        : ev_step_t'(quotient);

	always_ff @(posedge pix_clk)
	begin
		if (ev_state == EV_IDLE && stats_valid)
		begin
			target_snap <= target_q;
			dividend    <= weighted_sum;
			divisor     <= wsum_t'(pix_count);
		end
		else if (ev_state == EV_DIV_MEAN && div_done)
		begin
			dividend <= wsum_t'(`AE_EV_GAIN) * mean_gap;
			divisor  <= wsum_t'(target_snap);
			step_neg <= mean_gt;   // too bright, step down
		end
		else if (ev_state == EV_DIV_STEP && div_done)
			step_q <= step_neg ? -step_mag : step_mag;
	end

	ae_divider div_i (
		.pix_clk   (pix_clk),
		.reset     (reset),
		.div_start (div_start),
		.dividend  (dividend),
		.divisor   (divisor),
		.div_done  (div_done),
		.quotient  (quotient)
	);

	// index clamp
	assign idx_sum = $signed({2'b00, idx_q}) + step_q;
	always_comb
	begin
		if (idx_sum < 0)
			idx_next = '0;
		else if (idx_sum > `AE_IDX_MAX)
			idx_next = exp_idx_t'(`AE_IDX_MAX);
		else
			idx_next = idx_sum[`AE_IDX_W-1:0];
	end

	always_ff @(posedge pix_clk or posedge reset)
	begin
		if (reset)
		begin
			ev_state       <= EV_IDLE;
			div_start      <= 1'b0;
			idx_q          <= exp_idx_t'(`AE_IDX_DEFAULT);
			boot_q         <= 1'b0;
			brackets_valid <= 1'b0;
		end
		else
		begin
			boot_q         <= 1'b1;
			brackets_valid <= ~boot_q;   // one burst at the default index
			div_start      <= 1'b0;
			case (ev_state)
				EV_IDLE:
					if (stats_valid)
					begin
						div_start <= 1'b1;
						ev_state  <= EV_DIV_MEAN;
					end
				EV_DIV_MEAN:
					if (div_done)
					begin
						div_start <= 1'b1;
						ev_state  <= EV_DIV_STEP;
					end
				EV_DIV_STEP:
					if (div_done)
						ev_state <= EV_UPDATE;
				EV_UPDATE:
				begin
					idx_q          <= idx_next;
					brackets_valid <= 1'b1;
					ev_state       <= EV_IDLE;
				end
				default:
					ev_state <= EV_IDLE;
			endcase
		end
	end

	// brackets follow the index
	assign bracket_idx0 = (idx_q >= `AE_IDX_MAX - `AE_BRACKET_UP) ? exp_idx_t'(`AE_IDX_MAX)
	                                                            : idx_q + exp_idx_t'(`AE_BRACKET_UP);
	assign bracket_idx1 = idx_q;
	assign bracket_idx2 = (idx_q <= `AE_BRACKET_DN1) ? '0 : idx_q - exp_idx_t'(`AE_BRACKET_DN1);
	assign bracket_idx3 = (idx_q <= `AE_BRACKET_DN2) ? '0 : idx_q - exp_idx_t'(`AE_BRACKET_DN2);

endmodule

//--- design/ae_cfg_sender.sv
`timescale 1ns/1ps
`include "ae_defines.svh"

module ae_cfg_sender (
	input  logic              pix_clk,
	input  logic              reset,
	input  logic              brackets_valid,
	input  ae_pkg::exp_idx_t  bracket_idx0,
	input  ae_pkg::exp_idx_t  bracket_idx1,
	input  ae_pkg::exp_idx_t  bracket_idx2,
	input  ae_pkg::exp_idx_t  bracket_idx3,
	input  logic              credit_return,
	output logic              cfg_valid,
	output ae_pkg::bracket_t  cfg_sel,
	output ae_pkg::cfg_word_t cfg_it,
	output ae_pkg::cfg_word_t cfg_ag
);
	import ae_pkg::*;

	localparam int CR_W    = $clog2(`AE_CREDITS + 1);
	localparam int IT_KNEE = `AE_IT_MAX / `AE_IT_UNIT - 1;   // last index below max time

	send_state_t     send_state;
	exp_idx_t        pend_idx [4];
	exp_idx_t        act_idx [4];
	logic            pend_q;
	bracket_t        sel_q;
	logic [CR_W-1:0] credit_cnt;
	logic            issue;

	function automatic cfg_word_t table_it(exp_idx_t i);
		if (i <= IT_KNEE)
			return cfg_word_t'(`AE_IT_UNIT * (i + 1));
		return cfg_word_t'(`AE_IT_MAX);
	endfunction

	function automatic cfg_word_t table_ag(exp_idx_t i);
		if (i <= IT_KNEE)
			return cfg_word_t'(`AE_AG_UNITY);
		return cfg_word_t'(`AE_AG_UNITY + `AE_AG_STEP * (i - IT_KNEE));
	endfunction

	// the beat on the wire still holds a credit
	assign issue = (send_state == SND_SEND) && (credit_cnt > CR_W'(cfg_valid));

	always_ff @(posedge pix_clk or posedge reset)
	begin
		if (reset)
		begin
			send_state <= SND_IDLE;
			sel_q      <= '0;
			pend_q     <= 1'b0;
			credit_cnt <= CR_W'(`AE_CREDITS);
			cfg_valid  <= 1'b0;
		end
		else
		begin
			cfg_valid  <= issue;
			credit_cnt <= credit_cnt - CR_W'(cfg_valid) + CR_W'(credit_return);
			if (brackets_valid)
				pend_q <= 1'b1;
			case (send_state)
				SND_IDLE:
					if (pend_q)
					begin
						send_state <= SND_SEND;
						sel_q      <= '0;
						pend_q     <= brackets_valid;   // a new set queues again
					end
				SND_SEND:
					if (issue)
					begin
						sel_q <= sel_q + 1'b1;
						if (sel_q == 2'd3)
							send_state <= SND_IDLE;
					end
				default:
					send_state <= SND_IDLE;
			endcase
		end
	end

	always_ff @(posedge pix_clk)
	begin
		if (brackets_valid)
		begin
			pend_idx[0] <= bracket_idx0;
			pend_idx[1] <= bracket_idx1;
			pend_idx[2] <= bracket_idx2;
			pend_idx[3] <= bracket_idx3;
		end
		if (send_state == SND_IDLE && pend_q)
			act_idx <= pend_idx;
		if (issue)
		begin
			cfg_sel <= sel_q;
			cfg_it  <= table_it(act_idx[sel_q]);   // table lookup
			cfg_ag  <= table_ag(act_idx[sel_q]);
		end
	end

	a_credit_range: assert property (@(posedge pix_clk) disable iff (reset)
		credit_cnt <= `AE_CREDITS);

	// a returned credit must be one that is outstanding
	a_return_outstanding: assert property (@(posedge pix_clk) disable iff (reset)
		credit_return |-> (credit_cnt - CR_W'(cfg_valid)) < CR_W'(`AE_CREDITS));

endmodule

//--- design/ae_exposure_top.sv
`timescale 1ns/1ps

module ae_exposure_top (
	input  logic              pix_clk,
	input  logic              reset,
	input  logic              vs_in,
	input  logic              de_in,
	input  ae_pkg::pix_t      data_in,
	input  logic              ref_bri_up,
	input  logic              ref_bri_down,
	input  logic              credit_return,
	output logic              cfg_valid,
	output ae_pkg::bracket_t  cfg_sel,
	output ae_pkg::cfg_word_t cfg_it,
	output ae_pkg::cfg_word_t cfg_ag
);
	import ae_pkg::*;

	// histogram readout
	logic     bin_valid;
	pix_t     bin_index;
	bin_cnt_t bin_count;
	logic     bins_done;

	// frame totals
	logic     stats_valid;
	bin_cnt_t pix_count;
	wsum_t    weighted_sum;

	// bracket indices
	logic     brackets_valid;
	exp_idx_t bracket_idx0;
	exp_idx_t bracket_idx1;
	exp_idx_t bracket_idx2;
	exp_idx_t bracket_idx3;

	ae_histogram hist_i (
		.pix_clk   (pix_clk),
		.reset     (reset),
		.vs_in     (vs_in),
		.de_in     (de_in),
		.data_in   (data_in),
		.bin_valid (bin_valid),
		.bin_index (bin_index),
		.bin_count (bin_count),
		.bins_done (bins_done)
	);

	ae_frame_stats stats_i (
		.pix_clk      (pix_clk),
		.reset        (reset),
		.bin_valid    (bin_valid),
		.bin_index    (bin_index),
		.bin_count    (bin_count),
		.bins_done    (bins_done),
		.stats_valid  (stats_valid),
		.pix_count    (pix_count),
		.weighted_sum (weighted_sum)
	);

	ae_ev_control ev_i (
		.pix_clk        (pix_clk),
		.reset          (reset),
		.ref_bri_up     (ref_bri_up),
		.ref_bri_down   (ref_bri_down),
		.stats_valid    (stats_valid),
		.pix_count      (pix_count),
		.weighted_sum   (weighted_sum),
		.brackets_valid (brackets_valid),
		.bracket_idx0   (bracket_idx0),
		.bracket_idx1   (bracket_idx1),
		.bracket_idx2   (bracket_idx2),
		.bracket_idx3   (bracket_idx3)
	);

	ae_cfg_sender send_i (
		.pix_clk        (pix_clk),
		.reset          (reset),
		.brackets_valid (brackets_valid),
		.bracket_idx0   (bracket_idx0),
		.bracket_idx1   (bracket_idx1),
		.bracket_idx2   (bracket_idx2),
		.bracket_idx3   (bracket_idx3),
		.credit_return  (credit_return),
		.cfg_valid      (cfg_valid),
		.cfg_sel        (cfg_sel),
		.cfg_it         (cfg_it),
		.cfg_ag         (cfg_ag)
	);

endmodule

//--- verification/ae_exposure_tb.sv
`timescale 1ns/1ps
`include "ae_defines.svh"

module ae_exposure_tb;
	import ae_pkg::*;

	localparam int LINE_PIX     = 24;
	localparam int LINE_GAP     = 4;
	localparam int BEAT_TIMEOUT = 2000;   // cycles per beat
	localparam int TABLE_KNEE   = 63;     // last index with unity gain

	localparam int P_CONST = 0;
	localparam int P_ALT   = 1;
	localparam int P_RAND  = 2;

	typedef struct packed {
		int pat;
		int a;
		int b;
		int lines;
		int reps;
		int bri;       // >0 up pulses, <0 down pulses
		int delay;     // credit return delay in cycles
		int exp_idx;   // index after the last rep, -1 if not fixed
	} frame_row_t;

	logic      pix_clk;
	logic      reset;
	logic      vs_in;
	logic      de_in;
	pix_t      data_in;
	logic      ref_bri_up;
	logic      ref_bri_down;
	logic      credit_return;
	logic      cfg_valid;
	bracket_t  cfg_sel;
	cfg_word_t cfg_it;
	cfg_word_t cfg_ag;

	frame_row_t  frames [$];
	logic [1:0]  sel_q [$];
	logic [15:0] it_q [$];
	logic [15:0] ag_q [$];
	int          beat_stamp [$];   // cycle of each beat still owed a credit

	int errors        = 0;
	int checks        = 0;
	int cycle_cnt     = 0;
	int beats_seen    = 0;
	int credits_given = 0;
	int credit_delay  = 0;
	int stamp_drop;
	int seed_drop;
	bit monitor_on    = 1'b0;
	bit timed_out     = 1'b0;
	int idx_model;
	int target_model;

	ae_exposure_top dut_i (
		.pix_clk       (pix_clk),
		.reset         (reset),
		.vs_in         (vs_in),
		.de_in         (de_in),
		.data_in       (data_in),
		.ref_bri_up    (ref_bri_up),
		.ref_bri_down  (ref_bri_down),
		.credit_return (credit_return),
		.cfg_valid     (cfg_valid),
		.cfg_sel       (cfg_sel),
		.cfg_it        (cfg_it),
		.cfg_ag        (cfg_ag)
	);

	initial
	begin
		pix_clk = 1'b0;
		forever
			#5 pix_clk = ~pix_clk;
	end

	task automatic check_val(input string name, input logic [31:0] exp_v,
	                         input logic [31:0] act_v);
		checks++;
		if (act_v !== exp_v)
		begin
			errors++;
			$display("** Error at %t: %s expected %0d got %0d", $time, name, exp_v, act_v);
		end
	endtask

	// ==================================================
	// output monitor and credit return
	// ==================================================
	always @(posedge pix_clk)
	begin
		cycle_cnt = cycle_cnt + 1;
		if (monitor_on && cfg_valid === 1'b1)
		begin
			sel_q.push_back(cfg_sel);
			it_q.push_back(cfg_it);
			ag_q.push_back(cfg_ag);
			beat_stamp.push_back(cycle_cnt);
			beats_seen = beats_seen + 1;
			check_val("credits_over_limit", (beats_seen - credits_given) > `AE_CREDITS, 0);
		end
	end

	always @(negedge pix_clk)
	begin
		credit_return = 1'b0;
		if (beat_stamp.size() > 0 && cycle_cnt >= beat_stamp[0] + credit_delay)
		begin
			stamp_drop    = beat_stamp.pop_front();
			credit_return = 1'b1;   // one credit per cycle
			credits_given = credits_given + 1;
		end
	end

	// ==================================================
	// reference model
	// ==================================================
	function automatic int integration_for(input int i);
		if (i <= TABLE_KNEE)
			return `AE_IT_UNIT * (i + 1);
		return `AE_IT_MAX;
	endfunction

	function automatic int gain_for(input int i);
		if (i <= TABLE_KNEE)
			return `AE_AG_UNITY;
		return `AE_AG_UNITY + `AE_AG_STEP * (i - TABLE_KNEE);
	endfunction

	function automatic int bracket_of(input int idx, input int sel);
		int b;
		case (sel)
			0:       b = idx + `AE_BRACKET_UP;
			1:       b = idx;
			2:       b = idx - `AE_BRACKET_DN1;
			default: b = idx - `AE_BRACKET_DN2;
		endcase
		if (b > `AE_IDX_MAX)
			b = `AE_IDX_MAX;
		if (b < 0)
			b = 0;
		return b;
	endfunction

	function automatic int next_step(input int mean, input int target);
		int gap;
		int mag;
		gap = (mean > target) ? mean - target : target - mean;
		mag = (`AE_EV_GAIN * gap) / target;
		if (mag > `AE_EV_STEP_MAX)
			mag = `AE_EV_STEP_MAX;
		return (mean > target) ? -mag : mag;   // too bright steps down
	endfunction

	function automatic frame_row_t make_row(input int pat, input int a, input int b,
	                                        input int lines, input int reps, input int bri,
	                                        input int delay, input int exp_idx);
		frame_row_t r;
		r.pat     = pat;
		r.a       = a;
		r.b       = b;
		r.lines   = lines;
		r.reps    = reps;
		r.bri     = bri;
		r.delay   = delay;
		r.exp_idx = exp_idx;
		return r;
	endfunction

	// ==================================================
	// stimulus
	// ==================================================
	task automatic pulse_target(input int count);
		int n;
		int total;
		total = (count < 0) ? -count : count;
		for (n = 0; n < total; n++)
		begin
			if (count > 0)
				ref_bri_up = 1'b1;
			else
				ref_bri_down = 1'b1;
			repeat (3) @(negedge pix_clk);
			ref_bri_up   = 1'b0;
			ref_bri_down = 1'b0;
			repeat (3) @(negedge pix_clk);   // low long enough for the edge detector
			if (count > 0 && target_model <= `AE_TARGET_HI_LIMIT)
				target_model = target_model + `AE_TARGET_STEP;
			else if (count < 0 && target_model >= `AE_TARGET_LO_LIMIT)
				target_model = target_model - `AE_TARGET_STEP;
		end
	endtask

	task automatic drive_frame(input frame_row_t row, output int mean);
		int line;
		int px;
		int n;
		int v;
		int cnt;
		int wsum;
		n    = 0;
		cnt  = 0;
		wsum = 0;
		for (line = 0; line < row.lines; line++)
		begin
			for (px = 0; px < LINE_PIX; px++)
			begin
				case (row.pat)
					P_CONST: v = row.a;
					P_ALT:   v = (n % 2 != 0) ? row.b : row.a;
					default: v = $urandom % 256;
				endcase
				de_in   = 1'b1;
				data_in = pix_t'(v);
				cnt     = cnt + 1;
				wsum    = wsum + v;
				n       = n + 1;
				@(negedge pix_clk);
			end
			de_in = 1'b0;
			repeat (LINE_GAP) @(negedge pix_clk);
		end
		vs_in = 1'b1;   // frame end
		repeat (8) @(negedge pix_clk);
		vs_in = 1'b0;
		mean = (cnt == 0) ? 0 : wsum / cnt;
	endtask

	task automatic wait_beat(output bit ok);
		int waited;
		waited = 0;
		while (sel_q.size() == 0 && waited < BEAT_TIMEOUT)
		begin
			@(negedge pix_clk);
			waited++;
		end
		ok = (sel_q.size() != 0);
		if (!ok)
		begin
			errors++;
			timed_out = 1'b1;
			$display("timeout at %t: no cfg_valid beat within %0d cycles", $time, BEAT_TIMEOUT);
		end
	endtask

	task automatic expect_burst(input string tag);
		int s;
		int b;
		bit ok;
		logic [1:0]  sel;
		logic [15:0] it;
		logic [15:0] ag;
		for (s = 0; s < 4; s++)
		begin
			wait_beat(ok);
			if (!ok)
				return;
			sel = sel_q.pop_front();
			it  = it_q.pop_front();
			ag  = ag_q.pop_front();
			b   = bracket_of(idx_model, s);
			check_val({tag, " cfg_sel"}, s, sel);
			check_val({tag, " cfg_it"}, integration_for(b), it);
			check_val({tag, " cfg_ag"}, gain_for(b), ag);
		end
	endtask

	initial
	begin
		int r;
		int rep;
		int mean;
		frame_row_t row;

		$timeformat(-9, 0, " ns", 0);
		seed_drop     = $urandom(32'h0d91_200a);
		reset         = 1'b1;
		vs_in         = 1'b0;
		de_in         = 1'b0;
		data_in       = '0;
		ref_bri_up    = 1'b0;
		ref_bri_down  = 1'b0;
		credit_return = 1'b0;

		//                        pattern  a    b    lines reps bri  delay idx
		frames.push_back(make_row(P_CONST, 10,  0,   8,    6,   0,   0,    95));  // dark
		frames.push_back(make_row(P_CONST, 240, 0,   8,    13,  0,   0,    0));   // bright
		frames.push_back(make_row(P_ALT,   100, 101, 6,    2,   0,   0,    4));
		frames.push_back(make_row(P_ALT,   20,  21,  6,    1,   0,   0,    12));
		frames.push_back(make_row(P_CONST, 128, 0,   4,    1,   8,   0,    20));  // up to limit
		frames.push_back(make_row(P_CONST, 60,  0,   4,    1,   -12, 0,    12));  // down to limit
		frames.push_back(make_row(P_CONST, 128, 0,   4,    1,   4,   40,   7));   // slow credits
		frames.push_back(make_row(P_RAND,  0,   0,   10,   3,   2,   3,    -1));

		repeat (4) @(negedge pix_clk);
		reset = 1'b0;

		// histogram RAM powers up unknown, one empty frame zeroes it
		repeat (4) @(negedge pix_clk);
		vs_in = 1'b1;
		repeat (8) @(negedge pix_clk);
		vs_in = 1'b0;
		repeat (300) @(negedge pix_clk);
		reset = 1'b1;
		repeat (4) @(negedge pix_clk);
		monitor_on = 1'b1;
		reset      = 1'b0;

		idx_model    = `AE_IDX_DEFAULT;
		target_model = `AE_TARGET_DEFAULT;
		expect_burst("boot");

		for (r = 0; r < frames.size() && !timed_out; r++)
		begin
			row          = frames[r];
			credit_delay = row.delay;
			pulse_target(row.bri);
			for (rep = 0; rep < row.reps && !timed_out; rep++)
			begin
				drive_frame(row, mean);
				idx_model = idx_model + next_step(mean, target_model);
				if (idx_model > `AE_IDX_MAX)
					idx_model = `AE_IDX_MAX;
				if (idx_model < 0)
					idx_model = 0;
				expect_burst($sformatf("row %0d rep %0d", r, rep));
			end
			if (row.exp_idx >= 0)
				check_val($sformatf("row %0d exposure index", r), row.exp_idx, idx_model);
		end

		repeat (100) @(negedge pix_clk);
		check_val("extra beats", 0, sel_q.size());
		$display("checks: %0d  errors: %0d", checks, errors);
		if (errors == 0)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end

endmodule

//--- ae_exposure.f
+incdir+design
design/ae_pkg.sv
design/ae_histogram.sv
design/ae_frame_stats.sv
design/ae_divider.sv
design/ae_ev_control.sv
design/ae_cfg_sender.sv
design/ae_exposure_top.sv
verification/ae_exposure_tb.sv
